//--- verilog/msg_pkg.sv
`default_nettype none

package msg_pkg;

    // ========================================
    // Serial message framing
    // ========================================

    // Message bits after the start bit
    localparam int MsgLen = 64;

    // Type byte sits at the top of the message
    localparam int TypeLen = 8;

    // Argument fills the rest
    localparam int ArgLen = 56;

    // Reply is one full word, no start bit
    localparam int RespLen = 64;

    // Idle cycles before the first reply bit
    localparam int TurnaroundCycles = 8;

    localparam int LedWidth = 4;

    // Set in the type byte when the host wants a reply
    localparam int TypeRespBit = 7;

    // ========================================
    // Message type codes
    // ========================================

    localparam logic [TypeLen-1:0] MsgTypeNop = 8'h00;

    // Reply bit set
    localparam logic [TypeLen-1:0] MsgTypeEcho = 8'h81;

    localparam logic [TypeLen-1:0] MsgTypeLedSet = 8'h02;

    localparam logic [TypeLen-1:0] MsgTypeImgReset = 8'h03;

    // Reply bit set
    localparam logic [TypeLen-1:0] MsgTypeSdStatus = 8'h84;

    // ========================================
    // Argument views
    // ========================================

    // Control fields for LED set and image reset, LEDs lowest
    typedef struct packed {
        logic [50:0]         reserved;
        logic                img_rst;
        logic [LedWidth-1:0] led;
    } msg_ctrl_s;

    // Same argument word, read as echo payload or as control fields
    typedef union packed {
        logic [ArgLen-1:0] payload;
        msg_ctrl_s         ctrl;
    } msg_arg_u;

endpackage

`default_nettype wire

//--- verilog/sd_status_pkg.sv
`default_nettype none

package sd_status_pkg;

    // ========================================
    // CMD6 status block layout
    // ========================================

    // 512-bit block seen as 16-bit words
    localparam int BlockWords = 32;

    localparam int WordWidth = 16;

    // Word holding the access mode, first word is 0
    localparam int AccessModeWord = 8;

    // Access mode field inside that word, bits 11 to 8
    localparam int AccessModeLsb = 8;

    localparam int AccessModeWidth = 4;

endpackage

`default_nettype wire

//--- verilog/msg_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module msg_receiver (
    input  wire logic                       sd_datInWrite_clk,
    input  wire logic                       sd_datInWrite_rst_,
    input  wire logic                       spi_data_in,
    input  wire logic                       busy,
    output logic                            msg_valid,
    output logic [msg_pkg::MsgLen-1:0]      msg_word
);

    // ========================================
    // Receive FSM
    // ========================================

    // Low while idle, high while shifting message bits
    logic                                   shifting;
    logic [$clog2(msg_pkg::MsgLen)-1:0]     bit_cnt;
    logic [msg_pkg::MsgLen-1:0]             shift_reg;

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            shifting  <= 1'b0;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!shifting) begin
                // Line is ignored while a reply is on its way out
                if (spi_data_in && !busy) begin
                    shifting <= 1'b1;
                    bit_cnt  <= ($bits(bit_cnt))'(msg_pkg::MsgLen - 1);
                end
            end else begin
                if (bit_cnt == '0) begin
                    // last bit sampled this edge
                    shifting  <= 1'b0;
                    msg_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    // MSB first, so shift in from the bottom
    always_ff @(posedge sd_datInWrite_clk) begin
        if (shifting) begin
            shift_reg <= {shift_reg[msg_pkg::MsgLen-2:0], spi_data_in};
        end
    end

    assign msg_word = shift_reg;

    // ========================================
    // Checks
    // ========================================

    // Host must wait for the reply before sending again
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        msg_valid |-> !busy)
    else $error("message completed while a reply was pending");

endmodule

`default_nettype wire

//--- verilog/msg_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module msg_dispatcher (
    input  wire logic                                   sd_datInWrite_clk,
    input  wire logic                                   sd_datInWrite_rst_,
    input  wire logic                                   msg_valid,
    input  wire logic [msg_pkg::MsgLen-1:0]             msg_word,
    input  wire logic [sd_status_pkg::AccessModeWidth-1:0] access_mode,
    input  wire logic                                   mode_valid,
    output logic [msg_pkg::LedWidth-1:0]                led,
    output logic                                        img_rst_,
    output logic                                        resp_valid,
    output logic [msg_pkg::RespLen-1:0]                 resp_word
);

    // ========================================
    // Message split
    // ========================================

    logic [msg_pkg::TypeLen-1:0]    msg_type;
    msg_pkg::msg_arg_u              msg_arg;
    logic                           type_known;
    logic [msg_pkg::RespLen-1:0]    resp_next;

    assign msg_type = msg_word[msg_pkg::MsgLen-1 -: msg_pkg::TypeLen];
    assign msg_arg  = msg_word[msg_pkg::ArgLen-1:0];

    // ========================================
    // Type decode and reply build
    // ========================================

    always_comb begin
        type_known = 1'b0;
        resp_next  = '0;
        case (msg_type)
            msg_pkg::MsgTypeNop: begin
                type_known = 1'b1;
            end
            msg_pkg::MsgTypeEcho: begin
                type_known = 1'b1;
                // Payload on top, low byte zero
                resp_next  = {msg_arg.payload, {(msg_pkg::RespLen - msg_pkg::ArgLen){1'b0}}};
            end
            msg_pkg::MsgTypeLedSet: begin
                type_known = 1'b1;
            end
            msg_pkg::MsgTypeImgReset: begin
                type_known = 1'b1;
            end
            msg_pkg::MsgTypeSdStatus: begin
                type_known = 1'b1;
                resp_next  = {mode_valid, access_mode,
                              {(msg_pkg::RespLen - 1 - sd_status_pkg::AccessModeWidth){1'b0}}};
            end
            default: begin
                // unknown types are dropped silently
                type_known = 1'b0;
            end
        endcase
    end

    // ========================================
    // Control registers
    // ========================================

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            led        <= '0;
            img_rst_   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= msg_valid && type_known && msg_type[msg_pkg::TypeRespBit];
            if (msg_valid) begin
                if (msg_type == msg_pkg::MsgTypeLedSet) begin
                    led <= msg_arg.ctrl.led;
                end
                if (msg_type == msg_pkg::MsgTypeImgReset) begin
                    img_rst_ <= msg_arg.ctrl.img_rst;
                end
            end
        end
    end

    // Reply word, valid alongside resp_valid
    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid) begin
            resp_word <= resp_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/resp_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module resp_transmitter (
    input  wire logic                       sd_datInWrite_clk,
    input  wire logic                       sd_datInWrite_rst_,
    input  wire logic                       resp_valid,
    input  wire logic [msg_pkg::RespLen-1:0] resp_word,
    output logic                            busy,
    output logic                            spi_data_out,
    output logic                            spi_data_oe
);

    // ========================================
    // Turnaround and shift out
    // ========================================

    // busy without oe is the turnaround gap, oe is the shift phase
    logic [$clog2(msg_pkg::TurnaroundCycles)-1:0]   turn_cnt;
    logic [$clog2(msg_pkg::RespLen)-1:0]            bit_cnt;
    logic [msg_pkg::RespLen-1:0]                    shift_reg;

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            busy        <= 1'b0;
            spi_data_oe <= 1'b0;
            turn_cnt    <= '0;
            bit_cnt     <= '0;
        end else begin
            if (!busy) begin
                if (resp_valid) begin
                    busy     <= 1'b1;
                    turn_cnt <= ($bits(turn_cnt))'(msg_pkg::TurnaroundCycles - 1);
                end
            end else if (!spi_data_oe) begin
                // Give the host time to release the line
                if (turn_cnt == '0) begin
                    spi_data_oe <= 1'b1;
                    bit_cnt     <= ($bits(bit_cnt))'(msg_pkg::RespLen - 1);
                end else begin
                    turn_cnt <= turn_cnt - 1'b1;
                end
            end else begin
                if (bit_cnt == '0) begin
                    spi_data_oe <= 1'b0;
                    busy        <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_valid && !busy) begin
            shift_reg <= resp_word;
        end else if (spi_data_oe) begin
            shift_reg <= {shift_reg[msg_pkg::RespLen-2:0], 1'b0};
        end
    end

    // MSB leads; line held low when not driving
    assign spi_data_out = spi_data_oe & shift_reg[msg_pkg::RespLen-1];

    // ========================================
    // Checks
    // ========================================

    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        resp_valid |-> !busy)
    else $error("reply requested while the previous one is still going out");

endmodule

`default_nettype wire

//--- verilog/cmd6_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cmd6_capture (
    input  wire logic                                       sd_datInWrite_clk,
    input  wire logic                                       sd_datInWrite_rst_,
    input  wire logic                                       dat_block_start,
    input  wire logic                                       dat_valid,
    input  wire logic [sd_status_pkg::WordWidth-1:0]        dat_word,
    output logic [sd_status_pkg::AccessModeWidth-1:0]       access_mode,
    output logic                                            mode_valid
);

    // Counts 0..BlockWords, parks at BlockWords until rearmed
    logic [$clog2(sd_status_pkg::BlockWords):0] word_cnt;

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt    <= ($bits(word_cnt))'(sd_status_pkg::BlockWords);
            access_mode <= '0;
            mode_valid  <= 1'b0;
        end else if (dat_block_start) begin
            word_cnt   <= '0;
            mode_valid <= 1'b0;
        end else if (dat_valid && word_cnt != ($bits(word_cnt))'(sd_status_pkg::BlockWords)) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == ($bits(word_cnt))'(sd_status_pkg::AccessModeWord)) begin
                access_mode <= dat_word[sd_status_pkg::AccessModeLsb +:
                                        sd_status_pkg::AccessModeWidth];
                mode_valid  <= 1'b1;
            end
        end
    end

    // ========================================
    // Checks
    // ========================================

    // A block start and a data word never share a cycle
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        !(dat_block_start && dat_valid))
    else $error("dat_block_start and dat_valid high together");

endmodule

`default_nettype wire

//--- verilog/spi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top (
    input  wire logic                                   sd_datInWrite_clk,
    input  wire logic                                   sd_datInWrite_rst_,
    input  wire logic                                   spi_data_in,
    input  wire logic                                   dat_block_start,
    input  wire logic                                   dat_valid,
    input  wire logic [sd_status_pkg::WordWidth-1:0]    dat_word,
    output logic                                        spi_data_out,
    output logic                                        spi_data_oe,
    output logic [msg_pkg::LedWidth-1:0]                led,
    output logic                                        img_rst_
);

    // ========================================
    // Internal nets
    // ========================================

    logic                                       msg_valid;
    logic [msg_pkg::MsgLen-1:0]                 msg_word;
    logic                                       resp_valid;
    logic [msg_pkg::RespLen-1:0]                resp_word;
    logic                                       busy;
    logic [sd_status_pkg::AccessModeWidth-1:0]  access_mode;
    logic                                       mode_valid;

    // ========================================
    // Serial message path
    // ========================================

    msg_receiver msg_receiver0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .busy               (busy),
        .msg_valid          (msg_valid),
        .msg_word           (msg_word)
    );

    msg_dispatcher msg_dispatcher0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg_valid          (msg_valid),
        .msg_word           (msg_word),
        .access_mode        (access_mode),
        .mode_valid         (mode_valid),
        .led                (led),
        .img_rst_           (img_rst_),
        .resp_valid         (resp_valid),
        .resp_word          (resp_word)
    );

    resp_transmitter resp_transmitter0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp_valid         (resp_valid),
        .resp_word          (resp_word),
        .busy               (busy),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe)
    );

    // SD data-in side, feeds the status reply
    cmd6_capture cmd6_capture0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_block_start    (dat_block_start),
        .dat_valid          (dat_valid),
        .dat_word           (dat_word),
        .access_mode        (access_mode),
        .mode_valid         (mode_valid)
    );

endmodule

`default_nettype wire

//--- sim/tb_spi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge_top;

    // Longest wait for any DUT response, in clock cycles
    localparam int WaitCycles = 40;

    // Action taken on the SD data-in side before a row's message
    localparam int PreNone  = 0;
    localparam int PreBlock = 1;
    localparam int PreRearm = 2;

    logic                                   sd_datInWrite_clk;
    logic                                   sd_datInWrite_rst_;
    logic                                   spi_data_in;
    logic                                   dat_block_start;
    logic                                   dat_valid;
    logic [sd_status_pkg::WordWidth-1:0]    dat_word;
    logic                                   spi_data_out;
    logic                                   spi_data_oe;
    logic [msg_pkg::LedWidth-1:0]           led;
    logic                                   img_rst_;

    // Stimulus table, one entry per row in each queue
    string                                  row_name[$];
    logic [msg_pkg::MsgLen-1:0]             row_msg[$];
    int                                     row_pre[$];
    bit                                     row_has_resp[$];
    logic [msg_pkg::RespLen-1:0]            row_resp[$];
    logic [msg_pkg::LedWidth-1:0]           row_led[$];
    logic                                   row_img[$];

    spi_bridge_top dut0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .dat_block_start    (dat_block_start),
        .dat_valid          (dat_valid),
        .dat_word           (dat_word),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .led                (led),
        .img_rst_           (img_rst_)
    );

    initial sd_datInWrite_clk = 1'b0;
    always #20 sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ========================================
    // Checks
    // ========================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_resp(input string name, input logic [msg_pkg::RespLen-1:0] exp_val,
                              input logic [msg_pkg::RespLen-1:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("[FAIL] %s reply expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    task automatic check_led(input string name, input logic [msg_pkg::LedWidth-1:0] exp_val,
                             input logic [msg_pkg::LedWidth-1:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("[FAIL] %s led expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("[FAIL] %s img_rst_ expected %b actual %b",
                                name, exp_val, act_val));
        end
    endtask

    // ========================================
    // Host and data source models
    // ========================================

    // Start bit, then the message MSB first, then the line goes idle
    task automatic send_msg(input logic [msg_pkg::MsgLen-1:0] msg);
        @(posedge sd_datInWrite_clk);
        spi_data_in <= 1'b1;
        for (int i = msg_pkg::MsgLen - 1; i >= 0; i--) begin
            @(posedge sd_datInWrite_clk);
            spi_data_in <= msg[i];
        end
        @(posedge sd_datInWrite_clk);
        spi_data_in <= 1'b0;
    endtask

    // Outputs are sampled on the falling edge, away from DUT updates
    task automatic receive_resp(input string name, output logic [msg_pkg::RespLen-1:0] reply);
        int waited;
        waited = 0;
        reply  = '0;
        @(negedge sd_datInWrite_clk);
        while (!spi_data_oe) begin
            if (waited == WaitCycles) begin
                abort_run($sformatf("%s: no reply started within %0d cycles", name, WaitCycles));
            end
            waited++;
            @(negedge sd_datInWrite_clk);
        end
        for (int i = msg_pkg::RespLen - 1; i >= 0; i--) begin
            if (!spi_data_oe) begin
                abort_run($sformatf("%s: output enable dropped before the last reply bit", name));
            end
            reply[i] = spi_data_out;
            @(negedge sd_datInWrite_clk);
        end
        if (spi_data_oe) begin
            abort_run($sformatf("%s: output enable still high after the last reply bit", name));
        end
    endtask

    task automatic check_quiet(input string name);
        for (int i = 0; i < WaitCycles; i++) begin
            @(negedge sd_datInWrite_clk);
            if (spi_data_oe) begin
                abort_run($sformatf("%s: reply sent for a message that wants none", name));
            end
        end
    endtask

    // Full status block, random filler around the access-mode word
    task automatic send_block(input logic [sd_status_pkg::WordWidth-1:0] mode_word);
        logic [31:0] rnd;
        @(posedge sd_datInWrite_clk);
        dat_block_start <= 1'b1;
        for (int i = 0; i < sd_status_pkg::BlockWords; i++) begin
            rnd = $urandom;
            @(posedge sd_datInWrite_clk);
            dat_block_start <= 1'b0;
            dat_valid       <= 1'b1;
            if (i == sd_status_pkg::AccessModeWord) begin
                dat_word <= mode_word;
            end else begin
                dat_word <= rnd[sd_status_pkg::WordWidth-1:0];
            end
        end
        @(posedge sd_datInWrite_clk);
        dat_valid <= 1'b0;
    endtask

    task automatic start_block_only();
        @(posedge sd_datInWrite_clk);
        dat_block_start <= 1'b1;
        @(posedge sd_datInWrite_clk);
        dat_block_start <= 1'b0;
    endtask

    task automatic add_row(input string name, input logic [msg_pkg::MsgLen-1:0] msg,
                           input int pre, input bit has_resp,
                           input logic [msg_pkg::RespLen-1:0] resp,
                           input logic [msg_pkg::LedWidth-1:0] led_val, input logic img_val);
        row_name.push_back(name);
        row_msg.push_back(msg);
        row_pre.push_back(pre);
        row_has_resp.push_back(has_resp);
        row_resp.push_back(resp);
        row_led.push_back(led_val);
        row_img.push_back(img_val);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        logic [63:0]                                rnd64;
        logic [msg_pkg::ArgLen-1:0]                 payload;
        logic [31:0]                                rnd;
        logic [sd_status_pkg::WordWidth-1:0]        mode_word;
        logic [sd_status_pkg::AccessModeWidth-1:0]  mode_field;
        logic [msg_pkg::RespLen-1:0]                reply;

        sd_datInWrite_rst_ = 1'b0;
        spi_data_in        = 1'b0;
        dat_block_start    = 1'b0;
        dat_valid          = 1'b0;
        dat_word           = '0;
        void'($urandom(32'h0479_9ef1));

        // Access mode sits in bits 11 to 8 of the status word
        rnd        = $urandom;
        mode_word  = rnd[sd_status_pkg::WordWidth-1:0];
        mode_field = mode_word[11:8];

        add_row("sd_status_idle", {msg_pkg::MsgTypeSdStatus, 56'd0}, PreNone, 1'b1, '0,
                4'h0, 1'b0);
        add_row("echo_a", {msg_pkg::MsgTypeEcho, 56'h12_3456_789a_bcde}, PreNone, 1'b1,
                {56'h12_3456_789a_bcde, 8'h00}, 4'h0, 1'b0);
        add_row("echo_ones", {msg_pkg::MsgTypeEcho, 56'hff_ffff_ffff_ffff}, PreNone, 1'b1,
                {56'hff_ffff_ffff_ffff, 8'h00}, 4'h0, 1'b0);
        add_row("echo_ends", {msg_pkg::MsgTypeEcho, 56'h80_0000_0000_0001}, PreNone, 1'b1,
                {56'h80_0000_0000_0001, 8'h00}, 4'h0, 1'b0);
        for (int i = 0; i < 5; i++) begin
            rnd64   = {$urandom, $urandom};
            payload = rnd64[msg_pkg::ArgLen-1:0];
            add_row($sformatf("echo_rand_%0d", i), {msg_pkg::MsgTypeEcho, payload}, PreNone,
                    1'b1, {payload, 8'h00}, 4'h0, 1'b0);
        end
        // img_rst bit set here must not reach the sensor reset
        add_row("led_set_a", {msg_pkg::MsgTypeLedSet, 51'd0, 1'b1, 4'ha}, PreNone, 1'b0, '0,
                4'ha, 1'b0);
        add_row("led_set_5", {msg_pkg::MsgTypeLedSet, 51'd0, 1'b0, 4'h5}, PreNone, 1'b0, '0,
                4'h5, 1'b0);
        add_row("led_set_f", {msg_pkg::MsgTypeLedSet, 51'd0, 1'b0, 4'hf}, PreNone, 1'b0, '0,
                4'hf, 1'b0);
        add_row("led_set_3", {msg_pkg::MsgTypeLedSet, 51'd0, 1'b0, 4'h3}, PreNone, 1'b0, '0,
                4'h3, 1'b0);
        add_row("img_reset_high", {msg_pkg::MsgTypeImgReset, 51'd0, 1'b1, 4'hc}, PreNone,
                1'b0, '0, 4'h3, 1'b1);
        add_row("nop", {msg_pkg::MsgTypeNop, 56'd0}, PreNone, 1'b0, '0, 4'h3, 1'b1);
        add_row("unknown_7f", {8'h7f, 56'd0}, PreNone, 1'b0, '0, 4'h3, 1'b1);
        // Unknown type with the reply bit set still gets no reply
        add_row("unknown_ff", {8'hff, 51'd0, 1'b0, 4'h6}, PreNone, 1'b0, '0, 4'h3, 1'b1);
        add_row("img_reset_low", {msg_pkg::MsgTypeImgReset, 51'd0, 1'b0, 4'h9}, PreNone,
                1'b0, '0, 4'h3, 1'b0);
        add_row("sd_status_block", {msg_pkg::MsgTypeSdStatus, 56'd0}, PreBlock, 1'b1,
                {1'b1, mode_field, 59'd0}, 4'h3, 1'b0);
        // Block start clears only the valid flag
        add_row("sd_status_rearm", {msg_pkg::MsgTypeSdStatus, 56'd0}, PreRearm, 1'b1,
                {1'b0, mode_field, 59'd0}, 4'h3, 1'b0);
        add_row("echo_after", {msg_pkg::MsgTypeEcho, 56'h5a_a55a_a55a_a55a}, PreNone, 1'b1,
                {56'h5a_a55a_a55a_a55a, 8'h00}, 4'h3, 1'b0);

        repeat (2) @(posedge sd_datInWrite_clk);
        sd_datInWrite_rst_ <= 1'b1;

        @(negedge sd_datInWrite_clk);
        check_led("after_reset", 4'h0, led);
        check_bit("after_reset", 1'b0, img_rst_);
        if (spi_data_oe !== 1'b0) begin
            abort_run("spi_data_oe is not low after reset");
        end

        foreach (row_name[r]) begin
            if (row_pre[r] == PreBlock) begin
                send_block(mode_word);
            end else if (row_pre[r] == PreRearm) begin
                start_block_only();
            end
            send_msg(row_msg[r]);
            if (row_has_resp[r]) begin
                receive_resp(row_name[r], reply);
                check_resp(row_name[r], row_resp[r], reply);
            end else begin
                check_quiet(row_name[r]);
            end
            check_led(row_name[r], row_led[r], led);
            check_bit(row_name[r], row_img[r], img_rst_);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- spi_bridge_top.f
verilog/msg_pkg.sv
verilog/sd_status_pkg.sv
verilog/msg_receiver.sv
verilog/msg_dispatcher.sv
verilog/resp_transmitter.sv
verilog/cmd6_capture.sv
verilog/spi_bridge_top.sv
sim/tb_spi_bridge_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the bridge testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_bridge_top \
    -f spi_bridge_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_spi_bridge_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation passed$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
